// File: common/cpuPkg.sv
package cpuPkg;

  typedef logic [31:0] word_t;   // data, address or instruction
  typedef logic [4:0]  regIdx_t;

  localparam word_t   HALT_WORD = 32'hffff_ffff;
  localparam word_t   RESET_PC  = 32'h0000_0000;
  localparam regIdx_t REG_RA    = 5'd31; // link register for JAL

  typedef enum logic [5:0] {
    OP_RTYPE = 6'h00,
    OP_J     = 6'h02,
    OP_JAL   = 6'h03,
    OP_BEQ   = 6'h04,
    OP_BNE   = 6'h05,
    OP_ADDIU = 6'h09,
    OP_ORI   = 6'h0d,
    OP_LUI   = 6'h0f,
    OP_LW    = 6'h23,
    OP_SW    = 6'h2b,
    OP_HALT  = 6'h3f
  } opcode_t;

  typedef enum logic [5:0] {
    FN_SLL  = 6'h00,
    FN_JR   = 6'h08,
    FN_ADDU = 6'h21,
    FN_SUBU = 6'h23,
    FN_AND  = 6'h24,
    FN_OR   = 6'h25,
    FN_XOR  = 6'h26,
    FN_SLT  = 6'h2a
  } funct_t;

  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLT, ALU_SLL, ALU_LUI
  } aluOp_t;

  typedef struct packed {
    logic   regDst;   // rd instead of rt
    logic   aluSrc;   // immediate as operand B
    logic   shiftSel; // shamt as operand B
    logic   zeroExt;
    logic   memToReg;
    logic   dRen;
    logic   dWen;
    logic   regWen;
    logic   branch;
    logic   bne;
    logic   jmp;
    logic   jl;
    logic   jmpReg;
    logic   lui;
    logic   halt;
    aluOp_t aluOp;
  } ctrl_t;

  // one latch layout shared by all four stages
  typedef struct packed {
    logic  valid;
    ctrl_t ctrl;
    word_t instr;
    word_t pcPlus4;
    word_t rdat1;
    word_t rdat2;
    word_t aluRes;
    word_t loadData;
  } pipeReg_t;

  typedef struct packed {
    logic  ren;
    logic  wen;
    word_t addr;
    word_t wdata;
  } memReq_t;

  typedef enum logic [1:0] {GRANT_IDLE, GRANT_INSTR, GRANT_DATA} busGrant_t;

endpackage

// File: datapath/alu.sv
`timescale 1ns/1ps

module alu (
  input  cpuPkg::word_t  portA,
  input  cpuPkg::word_t  portB,
  input  cpuPkg::aluOp_t op,
  output cpuPkg::word_t  result,
  output logic           zero
);
  import cpuPkg::*;

  always_comb begin
    case (op)
      ALU_ADD: result = portA + portB;
      ALU_SUB: result = portA - portB;
      ALU_AND: result = portA & portB;
      ALU_OR:  result = portA | portB;
      ALU_XOR: result = portA ^ portB;
      ALU_SLT: result = {31'd0, $signed(portA) < $signed(portB)};
      ALU_SLL: result = portA << portB[4:0]; // shamt only
      ALU_LUI: result = {portB[15:0], 16'h0000};
      default: result = '0;
    endcase
  end

  assign zero = (result == '0);

endmodule

// File: datapath/registerFile.sv
`timescale 1ns/1ps

module registerFile (
  input  logic            CLK,
  input  logic            nRST,
  input  logic            wen,
  input  cpuPkg::regIdx_t wsel,
  input  cpuPkg::regIdx_t rsel1,
  input  cpuPkg::regIdx_t rsel2,
  input  cpuPkg::word_t   wdat,
  output cpuPkg::word_t   rdat1,
  output cpuPkg::word_t   rdat2
);
  import cpuPkg::*;

  word_t regs [32];

  // falling edge write, readers see it before the next rising edge
  always_ff @(negedge CLK or negedge nRST) begin
    if (!nRST) begin
      for (int i = 0; i < 32; i++)
        regs[i] <= '0;
    end else if (wen && (wsel != '0)) begin
      regs[wsel] <= wdat;
    end
  end

  assign rdat1 = regs[rsel1]; // r0 never written, stays zero
  assign rdat2 = regs[rsel2];

endmodule

// File: datapath/controlUnit.sv
`timescale 1ns/1ps

module controlUnit (
  input  cpuPkg::word_t instr,
  output cpuPkg::ctrl_t ctrl
);
  import cpuPkg::*;

  opcode_t opcode;
  funct_t  funct;

  assign opcode = opcode_t'(instr[31:26]);
  assign funct  = funct_t'(instr[5:0]);

  always_comb begin
    ctrl       = '0; // nop unless decoded below
    ctrl.aluOp = ALU_ADD;
    case (opcode)
      OP_RTYPE: begin
        ctrl.regDst = 1'b1;
        ctrl.regWen = 1'b1;
        case (funct)
          FN_ADDU: ctrl.aluOp = ALU_ADD;
          FN_SUBU: ctrl.aluOp = ALU_SUB;
          FN_AND:  ctrl.aluOp = ALU_AND;
          FN_OR:   ctrl.aluOp = ALU_OR;
          FN_XOR:  ctrl.aluOp = ALU_XOR;
          FN_SLT:  ctrl.aluOp = ALU_SLT;
          FN_SLL: begin
            ctrl.shiftSel = 1'b1;
            ctrl.aluOp    = ALU_SLL;
          end
          FN_JR: begin
            ctrl.regWen = 1'b0;
            ctrl.jmpReg = 1'b1;
          end
          default: begin
            ctrl.regDst = 1'b0;
            ctrl.regWen = 1'b0;
          end
        endcase
      end
      OP_ADDIU: begin
        ctrl.aluSrc = 1'b1;
        ctrl.regWen = 1'b1;
      end
      OP_ORI: begin
        ctrl.aluSrc  = 1'b1;
        ctrl.zeroExt = 1'b1;
        ctrl.regWen  = 1'b1;
        ctrl.aluOp   = ALU_OR;
      end
      OP_LUI: begin
        ctrl.aluSrc = 1'b1;
        ctrl.lui    = 1'b1;
        ctrl.regWen = 1'b1;
        ctrl.aluOp  = ALU_LUI;
      end
      OP_LW: begin
        ctrl.aluSrc   = 1'b1;
        ctrl.dRen     = 1'b1;
        ctrl.memToReg = 1'b1;
        ctrl.regWen   = 1'b1;
      end
      OP_SW: begin
        ctrl.aluSrc = 1'b1;
        ctrl.dWen   = 1'b1;
      end
      OP_BEQ, OP_BNE: begin
        ctrl.branch = 1'b1;
        ctrl.bne    = (opcode == OP_BNE);
        ctrl.aluOp  = ALU_SUB; // compare through the zero flag
      end
      OP_J:    ctrl.jmp = 1'b1;
      OP_JAL: begin
        ctrl.jmp    = 1'b1;
        ctrl.jl     = 1'b1;
        ctrl.regWen = 1'b1;
      end
      OP_HALT: ctrl.halt = (instr == HALT_WORD);
      default: ;
    endcase
  end

endmodule

// File: datapath/datapath.sv
`timescale 1ns/1ps

module datapath (
  input  logic            CLK,
  input  logic            nRST,
  output cpuPkg::memReq_t iReq,
  output cpuPkg::memReq_t dReq,
  input  cpuPkg::word_t   rdata,
  input  logic            ihit,
  input  logic            dhit,
  output logic            halt
);
  import cpuPkg::*;

  word_t    pc, pcPlus4, target;
  word_t    fetchBuf, loadBuf;
  logic     iDone, dDone;       // access finished, waiting for the advance
  logic     memAccess, advance, taken;
  pipeReg_t ifid, idex, exmem, memwb;
  pipeReg_t ifidNext, idexNext, exmemNext, memwbNext;
  ctrl_t    decCtrl;
  word_t    rdat1, rdat2;
  word_t    extImm, aluA, aluB, aluRes;
  logic     aluZero;
  logic     wbWen;
  regIdx_t  wsel;
  word_t    wdat;

  controlUnit ctrlDec (.instr(ifid.instr), .ctrl(decCtrl));

  registerFile regs (
    .CLK   (CLK),
    .nRST  (nRST),
    .wen   (wbWen),
    .wsel  (wsel),
    .rsel1 (ifid.instr[25:21]),
    .rsel2 (ifid.instr[20:16]),
    .wdat  (wdat),
    .rdat1 (rdat1),
    .rdat2 (rdat2)
  );

  alu aluUnit (
    .portA  (aluA),
    .portB  (aluB),
    .op     (idex.ctrl.aluOp),
    .result (aluRes),
    .zero   (aluZero)
  );

  assign pcPlus4   = pc + 32'd4;
  assign memAccess = exmem.valid & (exmem.ctrl.dRen | exmem.ctrl.dWen);
  // whole pipe moves only once fetch and any data access are both done
  assign advance   = ~halt & (ihit | iDone) & (~memAccess | dhit | dDone);

  always_comb begin
    iReq      = '0;
    iReq.ren  = ~halt & ~iDone; // fetch only, never writes
    iReq.addr = pc;
  end

  always_comb begin
    dReq       = '0;
    dReq.ren   = memAccess & exmem.ctrl.dRen & ~dDone & ~halt;
    dReq.wen   = memAccess & exmem.ctrl.dWen & ~dDone & ~halt;
    dReq.addr  = exmem.aluRes;
    dReq.wdata = exmem.rdat2;
  end

  // execute operands
  assign extImm = idex.ctrl.zeroExt ? {16'h0000, idex.instr[15:0]}
                                    : {{16{idex.instr[15]}}, idex.instr[15:0]};
  assign aluA   = idex.ctrl.shiftSel ? idex.rdat2 : idex.rdat1; // SLL shifts rt

  always_comb begin
    if (idex.ctrl.shiftSel)
      aluB = {27'd0, idex.instr[10:6]};
    else if (idex.ctrl.aluSrc)
      aluB = extImm;
    else
      aluB = idex.rdat2;
  end

  // branch and jump resolution
  always_comb begin
    taken  = 1'b0;
    target = idex.pcPlus4;
    if (idex.valid) begin
      if (idex.ctrl.jmpReg) begin
        taken  = 1'b1;
        target = idex.rdat1;
      end else if (idex.ctrl.jmp) begin
        taken  = 1'b1;
        target = {idex.pcPlus4[31:28], idex.instr[25:0], 2'b00};
      end else if (idex.ctrl.branch && (aluZero != idex.ctrl.bne)) begin
        taken  = 1'b1;
        target = idex.pcPlus4 + {extImm[29:0], 2'b00};
      end
    end
  end

  always_comb begin
    ifidNext         = '0;
    ifidNext.valid   = ~taken;
    ifidNext.instr   = ihit ? rdata : fetchBuf;
    ifidNext.pcPlus4 = pcPlus4;

    idexNext       = ifid;
    idexNext.valid = ifid.valid & ~taken; // squash the slot behind the branch
    idexNext.ctrl  = decCtrl;
    idexNext.rdat1 = rdat1;
    idexNext.rdat2 = rdat2;

    exmemNext        = idex;
    exmemNext.aluRes = aluRes;

    memwbNext          = exmem;
    memwbNext.loadData = dhit ? rdata : loadBuf;
  end

  // write-back, inputs are latched so a repeat while frozen is harmless
  assign wbWen = memwb.valid & memwb.ctrl.regWen;

  always_comb begin
    if (memwb.ctrl.jl)
      wsel = REG_RA;
    else if (memwb.ctrl.regDst)
      wsel = memwb.instr[15:11];
    else
      wsel = memwb.instr[20:16];
  end

  always_comb begin
    if (memwb.ctrl.lui)
      wdat = {memwb.instr[15:0], 16'h0000};
    else if (memwb.ctrl.jl)
      wdat = memwb.pcPlus4;
    else if (memwb.ctrl.memToReg)
      wdat = memwb.loadData;
    else
      wdat = memwb.aluRes;
  end

  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      pc    <= RESET_PC;
      ifid  <= '0;
      idex  <= '0;
      exmem <= '0;
      memwb <= '0;
      iDone <= 1'b0;
      dDone <= 1'b0;
      halt  <= 1'b0;
    end else if (advance) begin
      pc    <= taken ? target : pcPlus4;
      ifid  <= ifidNext;
      idex  <= idexNext;
      exmem <= exmemNext;
      memwb <= memwbNext;
      iDone <= 1'b0;
      dDone <= 1'b0;
      if (exmem.valid && exmem.ctrl.halt)
        halt <= 1'b1; // halt word entering write-back
    end else begin
      if (ihit)
        iDone <= 1'b1;
      if (dhit)
        dDone <= 1'b1;
    end
  end

  // rdata is shared, grab each word at its own hit
  always_ff @(posedge CLK) begin
    if (ihit)
      fetchBuf <= rdata;
    if (dhit)
      loadBuf <= rdata;
  end

endmodule

// File: design/memArbiter.sv
`timescale 1ns/1ps

module memArbiter (
  input  logic            CLK,
  input  logic            nRST,
  input  cpuPkg::memReq_t iReq,
  input  cpuPkg::memReq_t dReq,
  output cpuPkg::memReq_t memBus,
  input  logic            memReady,
  output logic            ihit,
  output logic            dhit
);
  import cpuPkg::*;

  busGrant_t grant, grantNext;
  logic      iWants, dWants;

  assign iWants = iReq.ren | iReq.wen;
  assign dWants = dReq.ren | dReq.wen;

  always_comb begin
    grantNext = grant;
    case (grant)
      GRANT_IDLE: begin
        if (dWants)
          grantNext = GRANT_DATA; // memory stage is older
        else if (iWants)
          grantNext = GRANT_INSTR;
      end
      GRANT_INSTR, GRANT_DATA: begin
        if (memReady)
          grantNext = GRANT_IDLE; // one idle cycle between grants
      end
      default: grantNext = GRANT_IDLE;
    endcase
  end

  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST)
      grant <= GRANT_IDLE;
    else
      grant <= grantNext;
  end

  always_comb begin
    case (grant)
      GRANT_INSTR: memBus = iReq;
      GRANT_DATA:  memBus = dReq;
      default:     memBus = '0;
    endcase
  end

  assign ihit = memReady & (grant == GRANT_INSTR);
  assign dhit = memReady & (grant == GRANT_DATA);

endmodule

// File: design/cpuTop.sv
`timescale 1ns/1ps

module cpuTop (
  input  logic            CLK,
  input  logic            nRST,
  output cpuPkg::memReq_t memBus,
  input  cpuPkg::word_t   memRdata,
  input  logic            memReady,
  output logic            halt
);
  import cpuPkg::*;

  memReq_t iReq, dReq;
  logic    ihit, dhit;

  datapath dp (
    .CLK   (CLK),
    .nRST  (nRST),
    .iReq  (iReq),
    .dReq  (dReq),
    .rdata (memRdata), // read data goes straight to both ports
    .ihit  (ihit),
    .dhit  (dhit),
    .halt  (halt)
  );

  memArbiter arb (
    .CLK      (CLK),
    .nRST     (nRST),
    .iReq     (iReq),
    .dReq     (dReq),
    .memBus   (memBus),
    .memReady (memReady),
    .ihit     (ihit),
    .dhit     (dhit)
  );

endmodule

// File: verif/tbMemory.sv
`timescale 1ns/1ps

module tbMemory (
  input  logic            CLK,
  input  logic            nRST,
  input  cpuPkg::memReq_t memBus,
  output cpuPkg::word_t   memRdata,
  output logic            memReady
);
  import cpuPkg::*;

  localparam int          WORDS     = 256; // 1 KiB, byte address bits 9:2
  localparam logic [31:0] LFSR_SEED = 32'hd4912e57;

  word_t       words [WORDS];
  logic [31:0] lfsr;

  // Fibonacci LFSR, taps 32 22 2 1
  function automatic logic [31:0] nextLfsr(input logic [31:0] state);
    return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
  endfunction

  initial begin
    memReq_t    req;
    logic [1:0] extraWait;
    logic [7:0] idx;
    memRdata = '0;
    memReady = 1'b0;
    lfsr     = LFSR_SEED;
    for (int i = 0; i < WORDS; i++)
      words[i] = '0; // all NOPs until the program is loaded
    forever begin
      @(negedge CLK);
      if (nRST && (memBus.ren || memBus.wen)) begin
        req          = memBus;
        idx          = req.addr[9:2];
        lfsr         = nextLfsr(lfsr);
        extraWait[0] = lfsr[0];
        lfsr         = nextLfsr(lfsr);
        extraWait[1] = lfsr[0];
        repeat (extraWait) @(negedge CLK); // 1 to 4 cycles in total
        if (req.wen)
          words[idx] = req.wdata;
        memRdata = words[idx];
        memReady = 1'b1;
        @(negedge CLK);
        memReady = 1'b0;
      end
    end
  end

endmodule

// File: verif/cpuBus_chk.sv
`timescale 1ns/1ps

module cpuBusChk (
  input logic            CLK,
  input logic            nRST,
  input cpuPkg::memReq_t memBus,
  input logic            memReady,
  input logic            ihit,
  input logic            dhit,
  input logic            halt
);
  int failCount = 0;

  // a granted request waits unchanged for its memReady
  busHeld: assert property (@(posedge CLK) disable iff (!nRST)
      ((memBus.ren || memBus.wen) && !memReady) |=> $stable(memBus))
    else begin
      failCount++;
      $error("bus request changed before memReady");
    end

  hitsExclusive: assert property (@(posedge CLK) disable iff (!nRST) !(ihit && dhit))
    else begin
      failCount++;
      $error("ihit and dhit high in the same cycle");
    end

  haltSticky: assert property (@(posedge CLK) disable iff (!nRST) halt |=> halt)
    else begin
      failCount++;
      $error("halt dropped without reset");
    end

endmodule

// bus side on the arbiter, halt flag on the datapath
bind memArbiter cpuBusChk busChk (
  .CLK(CLK), .nRST(nRST), .memBus(memBus), .memReady(memReady),
  .ihit(ihit), .dhit(dhit), .halt(1'b0)
);

bind datapath cpuBusChk haltChk (
  .CLK(CLK), .nRST(nRST), .memBus('0), .memReady(1'b0),
  .ihit(1'b0), .dhit(1'b0), .halt(halt)
);

// File: verif/cpuTb.sv
`timescale 1ns/1ps

module cpuTb;
  import cpuPkg::*;

  localparam int PROG_LEN    = 59;
  localparam int NUM_STORES  = 20;
  localparam int MAX_LATENCY = 4;
  // every word through five stages, fetch and data each at worst latency plus idle
  localparam int WATCHDOG_CYCLES = PROG_LEN * 5 * 2 * (MAX_LATENCY + 2) + 100;

  typedef struct packed {
    word_t addr;
    word_t data;
  } storeExp_t;

  logic    CLK;
  logic    nRST;
  memReq_t memBus;
  word_t   memRdata;
  logic    memReady;
  logic    halt;

  // two NOPs or independent words between a write and its first reader
  word_t progWords [PROG_LEN] = '{
    32'h24010007, 32'h2402fffd, 32'h34038001, 32'h3c041234, // addiu 7, addiu -3, ori, lui
    32'h00000000, 32'h00223021, 32'h00413823, 32'h0041402a, // nop, addu, subu, slt
    32'h0022482a, 32'h00225024, 32'h00645825, 32'h00436026, // slt, and, or, xor
    32'h00016900, 32'hac060300, 32'hac070304, 32'hac080308, // sll, stores of results
    32'hac09030c, 32'hac0a0310, 32'hac0b0314, 32'hac0c0318,
    32'hac0d031c, 32'hac020320, 32'hac030324, 32'hac040328, // immediates
    32'hac070330, 32'h8c0e0330, 32'h00000000, 32'h00000000, // sw, lw r14, nop, nop
    32'hac0e0334, 32'h14210002, 32'h24100011, 32'h00000000, // sw r14, bne, addiu r16
    32'h10210003, 32'h24110bad, 32'h24120bad, 32'hac0103f0, // beq to 36, markers
    32'hac100338, 32'hac11033c, 32'hac120340, 32'h0800002b, // j to 43
    32'h24130bad, 32'h24130bad, 32'hac0103f4, 32'hac130344,
    32'h0c000032, 32'h24140077, 32'h00000000, 32'h00000000, // jal 50, return lands at 45
    32'hac14034c, 32'h08000036, 32'hac1f0348, 32'h03e00008, // j 54, sw r31, jr r31
    32'hac0103f8, 32'hac0103fc, 32'hac010350, 32'hffffffff, // dead stores, last store, halt
    32'h00000000, 32'h00000000, 32'h00000000
  };

  storeExp_t expStores [NUM_STORES] = '{
    '{32'h0000_0300, 32'h0000_0004}, '{32'h0000_0304, 32'hffff_fff6}, // 7 + -3, -3 - 7
    '{32'h0000_0308, 32'h0000_0001}, '{32'h0000_030c, 32'h0000_0000}, // signed compares
    '{32'h0000_0310, 32'h0000_0005}, '{32'h0000_0314, 32'h1234_8001},
    '{32'h0000_0318, 32'hffff_7ffc}, '{32'h0000_031c, 32'h0000_0070}, // 7 << 4
    '{32'h0000_0320, 32'hffff_fffd}, '{32'h0000_0324, 32'h0000_8001},
    '{32'h0000_0328, 32'h1234_0000}, '{32'h0000_0330, 32'hffff_fff6},
    '{32'h0000_0334, 32'hffff_fff6}, '{32'h0000_0338, 32'h0000_0011},
    '{32'h0000_033c, 32'h0000_0000}, '{32'h0000_0340, 32'h0000_0000}, // markers never ran
    '{32'h0000_0344, 32'h0000_0000}, '{32'h0000_0348, 32'h0000_00b4}, // jal address + 4
    '{32'h0000_034c, 32'h0000_0077}, '{32'h0000_0350, 32'h0000_0007}
  };

  string storeName [NUM_STORES] = '{
    "addu", "subu", "slt negative", "slt positive", "and", "or", "xor", "sll",
    "addiu negative", "ori zero extend", "lui", "sw source", "lw round trip",
    "bne fall through", "beq skip 1", "beq skip 2", "j skip", "jal link",
    "jr return", "j to end"
  };

  cpuTop UUT (
    .CLK(CLK), .nRST(nRST), .memBus(memBus), .memRdata(memRdata),
    .memReady(memReady), .halt(halt)
  );

  tbMemory memModel (
    .CLK(CLK), .nRST(nRST), .memBus(memBus), .memRdata(memRdata), .memReady(memReady)
  );

  initial begin
    CLK = 1'b0;
    forever #4 CLK = ~CLK;
  end

  task automatic stopWithFailure(input string why);
    $display("%s", why);
    $display("Simulation finished: FAIL");
    $fatal(1, "stopped at first error");
  endtask

  task automatic compareWord(input string name, input word_t expected, input word_t actual);
    if (actual !== expected)
      stopWithFailure($sformatf("MISMATCH %s: expected %h, actual %h", name, expected, actual));
  endtask

  task automatic compareFlag(input string name, input logic expected, input logic actual);
    if (actual !== expected)
      stopWithFailure($sformatf("MISMATCH %s: expected %b, actual %b", name, expected, actual));
  endtask

  // next completed write on the bus, sampled at the rising edge
  task automatic waitStore(output memReq_t seen);
    do begin
      @(posedge CLK);
      if (halt)
        stopWithFailure("halt came before all expected stores were seen");
    end while (!(memReady && memBus.wen));
    seen = memBus;
  endtask

  initial begin : watchdog
    repeat (WATCHDOG_CYCLES) @(posedge CLK);
    stopWithFailure("watchdog expired, halt never came");
  end

  initial begin
    memReq_t seen;
    nRST = 1'b0;
    @(posedge CLK);
    for (int i = 0; i < PROG_LEN; i++)
      memModel.words[i] = progWords[i];
    repeat (4) @(posedge CLK);
    @(negedge CLK);
    nRST = 1'b1;

    for (int i = 0; i < NUM_STORES; i++) begin
      waitStore(seen);
      compareWord($sformatf("%s address", storeName[i]), expStores[i].addr, seen.addr);
      compareWord($sformatf("%s data", storeName[i]), expStores[i].data, seen.wdata);
    end

    while (!halt) begin
      @(posedge CLK);
      if (memReady && memBus.wen)
        stopWithFailure($sformatf("unexpected extra store to address %h", memBus.addr));
    end

    // the bus must stay quiet once halted
    repeat (4 * (MAX_LATENCY + 2)) begin
      @(posedge CLK);
      compareFlag("bus request after halt", 1'b0, memBus.ren | memBus.wen);
      compareFlag("halt held", 1'b1, halt);
    end

    if (UUT.arb.busChk.failCount + UUT.dp.haltChk.failCount == 0) begin
      $display("Simulation finished: PASS");
      $finish;
    end else begin
      stopWithFailure("a bus or halt assertion failed during the run");
    end
  end

endmodule

// File: verilog.f
common/cpuPkg.sv
datapath/alu.sv
datapath/registerFile.sv
datapath/controlUnit.sv
datapath/datapath.sv
design/memArbiter.sv
design/cpuTop.sv
verif/tbMemory.sv
verif/cpuBus_chk.sv
verif/cpuTb.sv
